// ==== compile.f ====
+incdir+.
elk_pkg.sv
elk_spram.sv
elk_mem_map.sv
elk_memory.sv
elk_mouse_axis.sv
elk_host_bridge.sv
tb_elk_host_bridge.sv

// ==== elk_host_bridge.sv ====
// Host bridge top for the Electron core: external memory plus mouse joystick emulation
`timescale 1ns/1ps

module elk_host_bridge (
	input  logic                   clk_sys,
	input  logic                   arst_n,
	input  elk_pkg::elk_bus_req_t  bus_req,
	output elk_pkg::elk_data_t     rdata,
	input  elk_pkg::elk_load_t     load,
	input  elk_pkg::elk_mouse_t    mouse,
	input  elk_pkg::elk_joy_t      joy,
	input  logic                   axis_disable,
	output elk_pkg::elk_axis_out_t axis
);
	// Same-cycle decode results
	elk_pkg::elk_region_e   region;
	elk_pkg::elk_mem_addr_t mem_addr;

	elk_mem_map u_mem_map (
		.addr    (bus_req.addr),
		.region  (region),
		.mem_addr(mem_addr)
	);

	elk_memory u_memory (
		.clk_sys (clk_sys),
		.arst_n  (arst_n),
		.bus_req (bus_req),
		.load    (load),
		.region  (region),
		.mem_addr(mem_addr),
		.rdata   (rdata)
	);

	// Analog axis path
	elk_mouse_axis u_mouse_axis (
		.clk_sys     (clk_sys),
		.arst_n      (arst_n),
		.mouse       (mouse),
		.joy         (joy),
		.axis_disable(axis_disable),
		.axis        (axis)
	);

endmodule

// ==== elk_macros.svh ====
// Shared widths, bank counts, mouse limits and region codes for the Electron host bridge
`ifndef ELK_MACROS_SVH
`define ELK_MACROS_SVH

// CPU bus address, 32 banks of 16 KB
`define ELK_ADDR_W 19
`define ELK_DATA_W 8

// Offset inside one 16 KB bank
`define ELK_BANK_W 14

// Bank counts of the two arrays
`define ELK_ROM_BANKS 7
`define ELK_RAM_BANKS 8

// Array address, 3 bank bits over the bank offset
`define ELK_MEM_AW 17

// Host download address
`define ELK_LOAD_AW 25

// Mouse emulation limits
`define ELK_DELTA_LIMIT 10
`define ELK_AXIS_MAX 127
`define ELK_AXIS_MIN 128

// Region codes
`define ELK_REGION_W 2
`define ELK_REGION_NONE 2'd0
`define ELK_REGION_ROM 2'd1
`define ELK_REGION_RAM 2'd2

`endif

// ==== elk_mem_map.sv ====
// Address decode of the 19-bit CPU bus into ROM and sideways RAM banks
`timescale 1ns/1ps
`include "elk_macros.svh"

module elk_mem_map (
	input  elk_pkg::elk_addr_t     addr,
	output elk_pkg::elk_region_e   region,
	output elk_pkg::elk_mem_addr_t mem_addr
);
	// Top five address bits select the 16 KB slot
	localparam int CODE_W     = `ELK_ADDR_W - `ELK_BANK_W;
	localparam int BANK_SEL_W = `ELK_MEM_AW - `ELK_BANK_W;
	// Sideways RAM starts at 1_00_00
	localparam logic [CODE_W-1:0] RAM_BASE = CODE_W'(16);

	logic [CODE_W-1:0]     code;
	logic [CODE_W-1:0]     ram_idx;
	logic [BANK_SEL_W-1:0] rom_bank;
	logic                  rom_hit;
	logic [BANK_SEL_W-1:0] bank;

	assign code    = addr[`ELK_ADDR_W-1:`ELK_BANK_W];
	assign ram_idx = code - RAM_BASE;

	//////////////////////////////////////////////////////////////////////
	// ROM slots
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		rom_hit  = 1'b1;
		rom_bank = '0;
		case (code)
			// Filing system ROM
			5'b0_01_00: rom_bank = BANK_SEL_W'(0);
			// OS, mirrored over two slots
			5'b0_10_00,
			5'b0_10_01: rom_bank = BANK_SEL_W'(1);
			// BASIC, mirrored too
			5'b0_10_10,
			5'b0_10_11: rom_bank = BANK_SEL_W'(2);
			5'b0_11_00: rom_bank = BANK_SEL_W'(3);
			5'b0_11_01: rom_bank = BANK_SEL_W'(4);
			5'b0_11_10: rom_bank = BANK_SEL_W'(5);
			5'b0_11_11: rom_bank = BANK_SEL_W'(6);
			default: begin
				rom_hit  = 1'b0;
				rom_bank = '0;
			end
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// Region select
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		region = elk_pkg::region_none;
		bank   = '0;
		// RAM codes 1_00_xx and 1_01_xx
		if (code >= RAM_BASE && ram_idx < CODE_W'(`ELK_RAM_BANKS)) begin
			region = elk_pkg::region_ram;
			bank   = ram_idx[BANK_SEL_W-1:0];
		end else if (rom_hit) begin
			region = elk_pkg::region_rom;
			bank   = rom_bank;
		end
	end

	// Offset inside the bank is untouched
	assign mem_addr = {bank, addr[`ELK_BANK_W-1:0]};

endmodule

// ==== elk_memory.sv ====
// External memory for the Electron core: ROM download, sideways RAM writes, read data select
`timescale 1ns/1ps
`include "elk_macros.svh"

module elk_memory (
	input  logic                   clk_sys,
	input  logic                   arst_n,
	input  elk_pkg::elk_bus_req_t  bus_req,
	input  elk_pkg::elk_load_t     load,
	input  elk_pkg::elk_region_e   region,
	input  elk_pkg::elk_mem_addr_t mem_addr,
	output elk_pkg::elk_data_t     rdata
);
	elk_pkg::elk_mem_addr_t rom_addr;
	logic                   rom_we;
	logic                   ram_we;
	logic                   we_n_q;
	elk_pkg::elk_region_e   region_q;
	elk_pkg::elk_data_t     rom_rdata;
	elk_pkg::elk_data_t     ram_rdata;

	//////////////////////////////////////////////////////////////////////
	// ROM and download path
	//////////////////////////////////////////////////////////////////////

	// Host owns the ROM address while a download runs
	assign rom_addr = load.active ? load.addr[`ELK_MEM_AW-1:0] : mem_addr;
	// Only image index 0 goes to ROM
	assign rom_we = load.active && load.wr && (load.index == '0);

	elk_spram #(
		.DATA_W(`ELK_DATA_W),
		.ADDR_W(`ELK_MEM_AW)
	) u_rom (
		.clk_sys(clk_sys),
		.addr   (rom_addr),
		.wdata  (load.data),
		.we     (rom_we),
		.rdata  (rom_rdata)
	);

	//////////////////////////////////////////////////////////////////////
	// Sideways RAM
	//////////////////////////////////////////////////////////////////////

	// Previous strobe and region of the pending read
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			we_n_q   <= 1'b1;
			region_q <= elk_pkg::region_none;
		end else begin
			we_n_q   <= bus_req.we_n;
			region_q <= region;
		end
	end

	// Falling edge of we_n, one write per strobe
	assign ram_we = (region == elk_pkg::region_ram) && !bus_req.we_n && we_n_q;

	elk_spram #(
		.DATA_W(`ELK_DATA_W),
		.ADDR_W(`ELK_MEM_AW)
	) u_ram (
		.clk_sys(clk_sys),
		.addr   (mem_addr),
		.wdata  (bus_req.wdata),
		.we     (ram_we),
		.rdata  (ram_rdata)
	);

	// Read data follows the region of the previous address
	always_comb begin
		case (region_q)
			elk_pkg::region_rom: rdata = rom_rdata;
			elk_pkg::region_ram: rdata = ram_rdata;
			default:             rdata = '0;
		endcase
	end

	// CPU is held off during a download
	a_no_ram_wr_load: assert property (@(posedge clk_sys) disable iff (!arst_n)
		ram_we |-> !load.active)
		else $error("elk_memory: RAM write during download");

endmodule

// ==== elk_mouse_axis.sv ====
// Mouse to analog joystick emulation with real joystick mux and core axis format
`timescale 1ns/1ps
`include "elk_macros.svh"

module elk_mouse_axis (
	input  logic                   clk_sys,
	input  logic                   arst_n,
	input  elk_pkg::elk_mouse_t    mouse,
	input  elk_pkg::elk_joy_t      joy,
	input  logic                   axis_disable,
	output elk_pkg::elk_axis_out_t axis
);
	localparam elk_pkg::elk_axis_t DELTA_HI = elk_pkg::elk_axis_t'(`ELK_DELTA_LIMIT);
	localparam elk_pkg::elk_axis_t DELTA_LO = -DELTA_HI;
	localparam elk_pkg::elk_axis_t AXIS_HI  = elk_pkg::elk_axis_t'(`ELK_AXIS_MAX);
	localparam elk_pkg::elk_axis_t AXIS_LO  = -elk_pkg::elk_axis_t'(`ELK_AXIS_MIN);

	logic               toggle_q;
	logic               emu_active;
	logic               packet;
	logic               clear;
	elk_pkg::elk_axis_t acc_x;
	elk_pkg::elk_axis_t acc_y;
	elk_pkg::elk_axis_t dx;
	elk_pkg::elk_axis_t dy;
	elk_pkg::elk_axis_t sum_x;
	elk_pkg::elk_axis_t sum_y;
	elk_pkg::elk_data_t src_x;
	elk_pkg::elk_data_t src_y;

	// Per packet limit
	function automatic elk_pkg::elk_axis_t clamp_delta(input elk_pkg::elk_axis_t d);
		if (d > DELTA_HI) return DELTA_HI;
		if (d < DELTA_LO) return DELTA_LO;
		return d;
	endfunction

	// Axis range limit
	function automatic elk_pkg::elk_axis_t saturate(input elk_pkg::elk_axis_t s);
		if (s > AXIS_HI) return AXIS_HI;
		if (s < AXIS_LO) return AXIS_LO;
		return s;
	endfunction

	// Core wants inverted offset binary
	function automatic elk_pkg::elk_data_t to_core(input elk_pkg::elk_data_t v);
		return 8'hFF - {~v[7], v[6:0]};
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Accumulation
	//////////////////////////////////////////////////////////////////////

	assign packet = mouse.toggle != toggle_q;
	assign clear  = joy.any_dir || joy.fire || axis_disable;

	// Sign bit over the delta byte
	assign dx = {mouse.x_sign, mouse.dx};
	assign dy = {mouse.y_sign, mouse.dy};
	// Screen y grows downwards, axis y upwards
	assign sum_x = acc_x + clamp_delta(dx);
	assign sum_y = acc_y - clamp_delta(dy);

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			toggle_q   <= 1'b0;
			emu_active <= 1'b0;
			acc_x      <= '0;
			acc_y      <= '0;
		end else begin
			toggle_q <= mouse.toggle;
			// Real joystick activity wins
			if (clear) begin
				emu_active <= 1'b0;
				acc_x      <= '0;
				acc_y      <= '0;
			end else if (packet) begin
				emu_active <= 1'b1;
				acc_x      <= saturate(sum_x);
				acc_y      <= saturate(sum_y);
			end
		end
	end

	// Source mux and format
	assign src_x     = emu_active ? acc_x[7:0] : joy.x;
	assign src_y     = emu_active ? acc_y[7:0] : joy.y;
	assign axis.x    = to_core(src_x);
	assign axis.y    = to_core(src_y);
	assign axis.fire = emu_active ? |mouse.buttons : joy.fire;

	a_acc_range: assert property (@(posedge clk_sys) disable iff (!arst_n)
		(acc_x >= AXIS_LO) && (acc_x <= AXIS_HI) && (acc_y >= AXIS_LO) && (acc_y <= AXIS_HI))
		else $error("elk_mouse_axis: accumulator out of range");

endmodule

// ==== elk_pkg.sv ====
// Types shared by the Electron memory system and the mouse axis emulator
`include "elk_macros.svh"

package elk_pkg;

	typedef logic [`ELK_ADDR_W-1:0] elk_addr_t;
	typedef logic [`ELK_DATA_W-1:0] elk_data_t;
	typedef logic [`ELK_MEM_AW-1:0] elk_mem_addr_t;
	// Signed, wide enough for a saturated axis plus one clamped delta
	typedef logic signed [8:0] elk_axis_t;

	// CPU side request, we_n active low as on the core
	typedef struct packed {
		logic      we_n;
		elk_addr_t addr;
		elk_data_t wdata;
	} elk_bus_req_t;

	// Host download port
	typedef struct packed {
		logic                   active;
		logic                   wr;
		logic [7:0]             index;
		logic [`ELK_LOAD_AW-1:0] addr;
		elk_data_t              data;
	} elk_load_t;

	// Mouse packet, toggle flips once per packet
	typedef struct packed {
		logic       toggle;
		logic       y_sign;
		logic       x_sign;
		logic [1:0] buttons;
		logic [7:0] dx;
		logic [7:0] dy;
	} elk_mouse_t;

	// Real analog joystick
	typedef struct packed {
		logic [7:0] x;
		logic [7:0] y;
		logic       fire;
		logic       any_dir;
	} elk_joy_t;

	// Axis in core format
	typedef struct packed {
		logic [7:0] x;
		logic [7:0] y;
		logic       fire;
	} elk_axis_out_t;

	typedef enum logic [`ELK_REGION_W-1:0] {
		region_none = `ELK_REGION_NONE,
		region_rom  = `ELK_REGION_ROM,
		region_ram  = `ELK_REGION_RAM
	} elk_region_e;

endpackage

// ==== elk_spram.sv ====
// Single-port synchronous RAM with registered read address
`timescale 1ns/1ps

module elk_spram #(
	parameter int DATA_W = 8,
	parameter int ADDR_W = 8
) (
	input  logic              clk_sys,
	input  logic [ADDR_W-1:0] addr,
	input  logic [DATA_W-1:0] wdata,
	input  logic              we,
	output logic [DATA_W-1:0] rdata
);
	localparam int DEPTH = 1 << ADDR_W;

	logic [DATA_W-1:0] mem [DEPTH];
	logic [ADDR_W-1:0] addr_q;

	// Address register, read sees a same-edge write
	always_ff @(posedge clk_sys) begin
		if (we) begin
			mem[addr] <= wdata;
		end
		addr_q <= addr;
	end

	assign rdata = mem[addr_q];

	// Write enable must always resolve
	a_we_known: assert property (@(posedge clk_sys) !$isunknown(we))
		else $error("elk_spram: write enable unknown");

endmodule

// ==== run.sh ====
#!/bin/sh
# Build and run the host bridge testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f compile.f \
	--top-module tb_elk_host_bridge -o sim_elk_host_bridge

out=$(./obj_dir/sim_elk_host_bridge)
echo "$out"
if echo "$out" | grep -q "^Testbench passed$"; then
	exit 0
fi
exit 1

// ==== tb_elk_host_bridge.sv ====
// Table-driven testbench for the Electron host bridge: ROM download, sideways RAM, mouse axis
`timescale 1ns/1ps

module tb_elk_host_bridge;

	localparam int REG_NONE = 0;
	localparam int REG_ROM  = 1;
	localparam int REG_RAM  = 2;
	// Longest row takes three clocks
	localparam int ROW_CYCLES = 3;

	typedef enum logic [2:0] {op_load, op_write, op_write_hold, op_read, op_mouse, op_joy} op_e;

	// aux holds load index, second write byte, buttons or joystick y
	// flags are {axis_disable, fire, any_dir}
	typedef struct packed {
		op_e              op;
		logic [24:0]      addr;
		logic [7:0]       data;
		logic [7:0]       aux;
		logic [2:0]       flags;
		logic signed [8:0] dx;
		logic signed [8:0] dy;
		logic [16:0]      expected;
	} row_t;

	logic                   clk_sys = 1'b0;
	logic                   arst_n;
	elk_pkg::elk_bus_req_t  bus_req;
	elk_pkg::elk_data_t     rdata;
	elk_pkg::elk_load_t     load;
	elk_pkg::elk_mouse_t    mouse;
	elk_pkg::elk_joy_t      joy;
	logic                   axis_disable;
	elk_pkg::elk_axis_out_t axis;

	row_t        table_q[$];
	logic [31:0] lcg_state = 32'h2851_c5ad;
	int          cycles = 0;
	int          limit = 1000;
	int          pass_rows = 0;
	int          fail_rows = 0;

	// Reference model state
	logic [7:0]  rom_m[int];
	logic [7:0]  ram_m[int];
	int          acc_x;
	int          acc_y;
	bit          emu;
	logic [1:0]  btn;
	logic [7:0]  jx;
	logic [7:0]  jy;
	logic [2:0]  jfl;

	elk_host_bridge uut (
		.clk_sys     (clk_sys),
		.arst_n      (arst_n),
		.bus_req     (bus_req),
		.rdata       (rdata),
		.load        (load),
		.mouse       (mouse),
		.joy         (joy),
		.axis_disable(axis_disable),
		.axis        (axis)
	);

	always #2 clk_sys = ~clk_sys;

	// Run limit
	always @(posedge clk_sys) begin
		cycles++;
		if (cycles > limit) begin
			$display("Timeout: no end of test after %0d cycles", limit);
			$display("Testbench failed");
			$finish;
		end
	end

	function automatic logic [7:0] lcg_byte();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state[23:16];
	endfunction

	function automatic logic [13:0] rand_off();
		logic [15:0] v;
		v = {lcg_byte(), lcg_byte()};
		return v[13:0];
	endfunction

	// Slot code to region and array address, straight from the memory map
	function automatic void decode_ref(input logic [18:0] a, output int region,
		output logic [16:0] arr);
		logic [4:0] c;
		logic [2:0] bank;
		c = a[18:14];
		region = REG_NONE;
		bank = 3'd0;
		if (c[4:3] == 2'b10) begin
			region = REG_RAM;
			bank = c[2:0];
		end else if (!c[4]) begin
			case (c[3:2])
				2'b01: if (c[1:0] == 2'b00) region = REG_ROM;
				2'b10: begin
					region = REG_ROM;
					bank = 3'd1 + {2'b00, c[1]};
				end
				2'b11: begin
					region = REG_ROM;
					bank = 3'd3 + {1'b0, c[1:0]};
				end
				default: ;
			endcase
		end
		arr = {bank, a[13:0]};
	endfunction

	function automatic int clamp_ref(input int d);
		return (d > 10) ? 10 : (d < -10) ? -10 : d;
	endfunction

	function automatic int sat_ref(input int s);
		return (s > 127) ? 127 : (s < -128) ? -128 : s;
	endfunction

	// Inverted offset binary as the core reads it
	function automatic logic [7:0] core_fmt(input logic [7:0] src);
		return 8'd255 - (src ^ 8'h80);
	endfunction

	function automatic logic [16:0] axis_ref();
		logic [7:0] sx;
		logic [7:0] sy;
		sx = emu ? 8'(acc_x) : jx;
		sy = emu ? 8'(acc_y) : jy;
		return {core_fmt(sx), core_fmt(sy), emu ? |btn : jfl[1]};
	endfunction

	task automatic add_row(input op_e op, input logic [24:0] addr, input logic [7:0] data,
		input logic [7:0] aux, input logic [2:0] flags, input int dx, input int dy);
		row_t r;
		r = '0;
		r.op = op;
		r.addr = addr;
		r.data = data;
		r.aux = aux;
		r.flags = flags;
		r.dx = 9'(dx);
		r.dy = 9'(dy);
		table_q.push_back(r);
	endtask

	task automatic build_table();
		logic [13:0] rom_off[7];
		logic [13:0] ram_off[8];
		logic [13:0] hold_off;
		logic [7:0]  hold_byte;
		logic [16:0] arr;
		logic [7:0]  x;
		logic [7:0]  y;
		int          region;
		///////////////////////////////////////////////////////////////////////
		// ROM download and read back over every slot code
		///////////////////////////////////////////////////////////////////////
		for (int b = 0; b < 7; b++) begin
			rom_off[b] = rand_off();
			add_row(op_load, {8'hA5, 3'(b), rom_off[b]}, lcg_byte(), 8'd0, 3'd0, 0, 0);
		end
		// Other image index, ignored
		add_row(op_load, {8'h00, 3'd0, rom_off[0]}, lcg_byte(), 8'd1, 3'd0, 0, 0);
		for (int c = 0; c < 32; c++) begin
			decode_ref({5'(c), 14'd0}, region, arr);
			if (region == REG_ROM)
				add_row(op_read, {6'd0, 5'(c), rom_off[arr[16:14]]}, 8'd0, 8'd0, 3'd0, 0, 0);
		end
		///////////////////////////////////////////////////////////////////////
		// Sideways RAM
		///////////////////////////////////////////////////////////////////////
		for (int b = 0; b < 8; b++) begin
			ram_off[b] = rand_off();
			add_row(op_write, {6'd0, 2'b10, 3'(b), ram_off[b]}, lcg_byte(), 8'd0, 3'd0, 0, 0);
		end
		hold_off = rand_off();
		hold_byte = lcg_byte();
		// Second byte differs in every bit from the first
		add_row(op_write_hold, {6'd0, 5'b10101, hold_off}, hold_byte, ~hold_byte, 3'd0, 0, 0);
		for (int b = 0; b < 8; b++)
			add_row(op_read, {6'd0, 2'b10, 3'(b), ram_off[b]}, 8'd0, 8'd0, 3'd0, 0, 0);
		add_row(op_read, {6'd0, 5'b10101, hold_off}, 8'd0, 8'd0, 3'd0, 0, 0);
		// Unmapped slots at offsets already used in RAM
		add_row(op_write, {6'd0, 5'b11000, ram_off[0]}, lcg_byte(), 8'd0, 3'd0, 0, 0);
		add_row(op_write, {6'd0, 5'b00000, ram_off[1]}, lcg_byte(), 8'd0, 3'd0, 0, 0);
		add_row(op_write, {6'd0, 5'b11111, ram_off[2]}, lcg_byte(), 8'd0, 3'd0, 0, 0);
		add_row(op_read, {6'd0, 5'b11000, ram_off[0]}, 8'd0, 8'd0, 3'd0, 0, 0);
		add_row(op_read, {6'd0, 5'b00000, ram_off[1]}, 8'd0, 8'd0, 3'd0, 0, 0);
		add_row(op_read, {6'd0, 5'b11111, ram_off[2]}, 8'd0, 8'd0, 3'd0, 0, 0);
		for (int b = 0; b < 3; b++)
			add_row(op_read, {6'd0, 2'b10, 3'(b), ram_off[b]}, 8'd0, 8'd0, 3'd0, 0, 0);
		///////////////////////////////////////////////////////////////////////
		// Mouse emulation and joystick takeover
		///////////////////////////////////////////////////////////////////////
		add_row(op_mouse, '0, 8'd0, 8'd0, 3'd0, 3, -7);
		add_row(op_mouse, '0, 8'd0, 8'd0, 3'd0, -200, -90);
		// Drive x to the top and y to the bottom
		for (int k = 0; k < 28; k++)
			add_row(op_mouse, '0, 8'd0, 8'd0, 3'd0, 45, 30);
		x = lcg_byte();
		y = lcg_byte();
		add_row(op_joy, '0, x, y, 3'b001, 0, 0);
		add_row(op_joy, '0, x, y, 3'b000, 0, 0);
		add_row(op_mouse, '0, 8'd0, 8'd1, 3'd0, 45, 0);
		add_row(op_joy, '0, x, y, 3'b010, 0, 0);
		add_row(op_joy, '0, x, y, 3'b000, 0, 0);
		add_row(op_mouse, '0, 8'd0, 8'd2, 3'd0, -5, 5);
		add_row(op_mouse, '0, 8'd0, 8'd0, 3'd0, 120, -130);
		add_row(op_joy, '0, x, y, 3'b100, 0, 0);
		// Packet under axis_disable is dropped
		add_row(op_mouse, '0, 8'd0, 8'd1, 3'd0, 7, 7);
		add_row(op_joy, '0, x, y, 3'b000, 0, 0);
	endtask

	// Walk the table once through the reference model
	task automatic predict();
		logic [16:0] arr;
		int          region;
		foreach (table_q[i]) begin
			case (table_q[i].op)
				op_load: begin
					if (table_q[i].aux == 8'd0)
						rom_m[int'(table_q[i].addr[16:0])] = table_q[i].data;
				end
				op_write, op_write_hold: begin
					decode_ref(table_q[i].addr[18:0], region, arr);
					if (region == REG_RAM) ram_m[int'(arr)] = table_q[i].data;
				end
				op_read: begin
					decode_ref(table_q[i].addr[18:0], region, arr);
					if (region == REG_ROM) table_q[i].expected = {9'd0, rom_m[int'(arr)]};
					else if (region == REG_RAM) table_q[i].expected = {9'd0, ram_m[int'(arr)]};
					else table_q[i].expected = '0;
				end
				op_mouse: begin
					btn = table_q[i].aux[1:0];
					if (jfl == 3'd0) begin
						emu = 1'b1;
						acc_x = sat_ref(acc_x + clamp_ref(int'(table_q[i].dx)));
						acc_y = sat_ref(acc_y - clamp_ref(int'(table_q[i].dy)));
					end
					table_q[i].expected = axis_ref();
				end
				default: begin
					jx = table_q[i].data;
					jy = table_q[i].aux;
					jfl = table_q[i].flags;
					if (jfl != 3'd0) begin
						emu = 1'b0;
						acc_x = 0;
						acc_y = 0;
					end
					table_q[i].expected = axis_ref();
				end
			endcase
		end
	endtask

	task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] want,
		inout bit ok);
		assert (got === want) else begin
			$display("Mismatch at %0t: %s got %02h expected %02h", $time, name, got, want);
			ok = 1'b0;
		end
	endtask

	task automatic check_axis(input logic [16:0] want, inout bit ok);
		check_byte("axis.x", axis.x, want[16:9], ok);
		check_byte("axis.y", axis.y, want[8:1], ok);
		check_byte("axis.fire", {7'd0, axis.fire}, {7'd0, want[0]}, ok);
	endtask

	task automatic apply_row(input int i);
		row_t r;
		bit   ok;
		r = table_q[i];
		ok = 1'b1;
		@(negedge clk_sys);
		case (r.op)
			op_load: begin
				load.active = 1'b1;
				load.wr = 1'b1;
				load.index = r.aux;
				load.addr = r.addr;
				load.data = r.data;
				@(negedge clk_sys);
				load = '0;
			end
			op_write, op_write_hold: begin
				bus_req.addr = r.addr[18:0];
				bus_req.wdata = r.data;
				bus_req.we_n = 1'b0;
				@(negedge clk_sys);
				// Strobe still low, new byte must not land
				if (r.op == op_write_hold) begin
					bus_req.wdata = r.aux;
					@(negedge clk_sys);
				end
				bus_req.we_n = 1'b1;
			end
			op_read: begin
				bus_req.addr = r.addr[18:0];
				bus_req.we_n = 1'b1;
				@(negedge clk_sys);
				check_byte("rdata", rdata, r.expected[7:0], ok);
			end
			op_mouse: begin
				mouse.toggle = ~mouse.toggle;
				mouse.x_sign = r.dx[8];
				mouse.dx = r.dx[7:0];
				mouse.y_sign = r.dy[8];
				mouse.dy = r.dy[7:0];
				mouse.buttons = r.aux[1:0];
				@(negedge clk_sys);
				check_axis(r.expected, ok);
			end
			default: begin
				joy.x = r.data;
				joy.y = r.aux;
				joy.any_dir = r.flags[0];
				joy.fire = r.flags[1];
				axis_disable = r.flags[2];
				@(negedge clk_sys);
				check_axis(r.expected, ok);
			end
		endcase
		if (ok) pass_rows++;
		else fail_rows++;
		$display("row %0d op %0d: %s", i, r.op, ok ? "ok" : "FAILED");
	endtask

	initial begin
		arst_n = 1'b0;
		bus_req = '0;
		bus_req.we_n = 1'b1;
		load = '0;
		mouse = '0;
		joy = '0;
		axis_disable = 1'b0;
		acc_x = 0;
		acc_y = 0;
		emu = 1'b0;
		btn = 2'b00;
		jx = 8'd0;
		jy = 8'd0;
		jfl = 3'd0;
		build_table();
		predict();
		limit = 2 * table_q.size() * ROW_CYCLES + 20;
		repeat (2) @(posedge clk_sys);
		@(negedge clk_sys);
		arst_n = 1'b1;
		foreach (table_q[i])
			apply_row(i);
		$display("Rows: %0d run, %0d passed, %0d failed", table_q.size(), pass_rows, fail_rows);
		if (fail_rows == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule
